// File: src/exec_pipe_pkg.sv
package exec_pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN       = 64;             // Integer register width
    localparam int REG_ADDR_W = 5;              // x0 .. x31
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;             // Issued immediate, sign-extended to XLEN
    localparam int SHAMT_W    = $clog2(XLEN);   // Shift amount taken from operand B

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,     // Low SHAMT_W bits of operand B
        OP_SRL  = 4'd6,     // Logical, zero fill
        OP_SLT  = 4'd7,     // Signed compare, result 1 or 0
        OP_ADDI = 4'd8      // Operand B is the immediate
    } alu_op_e;

    // Codes 9 to 15 are unused and never issued

endpackage

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rf_raddr1,
    input  logic [REG_ADDR_W-1:0] rf_raddr2,
    input  logic                  wb_we,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       rf_rdata1,
    output logic [XLEN-1:0]       rf_rdata2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    // Read with write-through, covers the instruction three ahead
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;                              // x0 always reads zero
        end else if (wb_we && (addr == wb_rd)) begin
            return wb_data;                         // Same-cycle write wins
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rf_rdata1 = read_port(rf_raddr1);
    assign rf_rdata2 = read_port(rf_raddr2);

    // The writeback stage must already have masked every x0 destination
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_we |-> (wb_rd != '0)
    ) else $error("reg_file: write enable raised for x0");

endmodule

// File: src/issue_stage.sv
`timescale 1ns/10ps

module issue_stage
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_op_e               issue_op,
    input  logic [REG_ADDR_W-1:0] issue_rs1,
    input  logic [REG_ADDR_W-1:0] issue_rs2,
    input  logic [REG_ADDR_W-1:0] issue_rd,
    input  logic [IMM_W-1:0]      issue_imm,
    input  logic [XLEN-1:0]       rf_rdata1,
    input  logic [XLEN-1:0]       rf_rdata2,
    output logic [REG_ADDR_W-1:0] rf_raddr1,
    output logic [REG_ADDR_W-1:0] rf_raddr2,
    output logic                  ex_valid,
    output alu_op_e               ex_op,
    output logic [REG_ADDR_W-1:0] ex_rs1,
    output logic [REG_ADDR_W-1:0] ex_rs2,
    output logic [REG_ADDR_W-1:0] ex_rd,
    output logic [XLEN-1:0]       ex_opa,
    output logic [XLEN-1:0]       ex_opb
);

    logic [XLEN-1:0] imm_ext;
    logic            is_addi;

    assign rf_raddr1 = issue_rs1;                   // Register read happens in the issue cycle
    assign rf_raddr2 = issue_rs2;

    assign imm_ext = {{(XLEN-IMM_W){issue_imm[IMM_W-1]}}, issue_imm};
    assign is_addi = (issue_op == OP_ADDI);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ID/EX register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_op  <= issue_op;
            ex_rs1 <= issue_rs1;
            ex_rs2 <= is_addi ? '0 : issue_rs2;     // x0 is never forwarded, imm passes through
            ex_rd  <= issue_rd;
            ex_opa <= rf_rdata1;
            ex_opb <= is_addi ? imm_ext : rf_rdata2;
        end
    end

    a_issue_op_defined: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_valid |-> (!$isunknown(issue_op) && (issue_op <= OP_ADDI))
    ) else $error("issue_stage: undefined opcode %0d issued", issue_op);

endmodule

// File: src/operand_forward.sv
`timescale 1ns/10ps

module operand_forward
    import exec_pipe_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] ex_rs1,
    input  logic [REG_ADDR_W-1:0] ex_rs2,
    input  logic [XLEN-1:0]       ex_opa,
    input  logic [XLEN-1:0]       ex_opb,
    input  logic                  mem_valid,    // Instruction one ahead
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  logic [XLEN-1:0]       mem_data,
    input  logic                  wb_we,        // Instruction two ahead
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       fwd_opa,
    output logic [XLEN-1:0]       fwd_opb
);

    // One bypass selection, youngest producer first.
    // Each operand gets its own, so both can be forwarded in the same cycle.
    function automatic logic [XLEN-1:0] select_operand(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [XLEN-1:0]       reg_val
    );
        logic hit_mem;
        logic hit_wb;
        hit_mem = mem_valid && (rs != '0) && (rs == mem_rd);
        hit_wb  = wb_we && (rs == wb_rd);           // wb_we already excludes x0
        if (hit_mem) begin
            return mem_data;                        // EX/MEM result
        end else if (hit_wb) begin
            return wb_data;                         // MEM/WB result
        end
        return reg_val;                             // Value read at issue
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bypass muxes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign fwd_opa = select_operand(ex_rs1, ex_opa);
    assign fwd_opb = select_operand(ex_rs2, ex_opb);

endmodule

// File: src/alu_exec.sv
`timescale 1ns/10ps

module alu_exec
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  alu_op_e               ex_op,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       fwd_opa,
    input  logic [XLEN-1:0]       fwd_opb,
    output logic                  mem_valid,
    output logic [REG_ADDR_W-1:0] mem_rd,
    output logic [XLEN-1:0]       mem_data
);

    logic [XLEN-1:0]    alu_res;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;

    assign shamt     = fwd_opb[SHAMT_W-1:0];        // Upper bits of B ignored for shifts
    assign lt_signed = $signed(fwd_opa) < $signed(fwd_opb);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (ex_op)
            OP_ADD,
            OP_ADDI: alu_res = fwd_opa + fwd_opb;   // Immediate already sits in operand B
            OP_SUB:  alu_res = fwd_opa - fwd_opb;
            OP_AND:  alu_res = fwd_opa & fwd_opb;
            OP_OR:   alu_res = fwd_opa | fwd_opb;
            OP_XOR:  alu_res = fwd_opa ^ fwd_opb;
            OP_SLL:  alu_res = fwd_opa << shamt;
            OP_SRL:  alu_res = fwd_opa >> shamt;
            OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_signed};
            default: alu_res = '0;                  // Unused codes
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // EX/MEM register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            mem_rd   <= ex_rd;
            mem_data <= alu_res;
        end
    end

endmodule

// File: src/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_valid,
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  logic [XLEN-1:0]       mem_data,
    output logic                  wb_we,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  result_valid,
    output logic [REG_ADDR_W-1:0] result_rd,
    output logic [XLEN-1:0]       result_data
);

    logic wb_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
            wb_we    <= mem_valid && (mem_rd != '0);   // x0 results retire but never write
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_data;
    end

    assign result_valid = wb_valid;                 // Retire port is MEM/WB as is
    assign result_rd    = wb_rd;
    assign result_data  = wb_data;

    a_we_with_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_we |-> (result_valid && (result_rd != '0))
    ) else $error("writeback_stage: write enable without a retiring result");

endmodule

// File: src/exec_pipe_top.sv
`timescale 1ns/10ps

module exec_pipe_top
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_op_e               issue_op,
    input  logic [REG_ADDR_W-1:0] issue_rs1,
    input  logic [REG_ADDR_W-1:0] issue_rs2,
    input  logic [REG_ADDR_W-1:0] issue_rd,
    input  logic [IMM_W-1:0]      issue_imm,
    output logic                  result_valid,
    output logic [REG_ADDR_W-1:0] result_rd,
    output logic [XLEN-1:0]       result_data
);

    logic [REG_ADDR_W-1:0] rf_raddr1, rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1, rf_rdata2;
    logic                  ex_valid;
    alu_op_e               ex_op;
    logic [REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [XLEN-1:0]       ex_opa, ex_opb;
    logic [XLEN-1:0]       fwd_opa, fwd_opb;
    logic                  mem_valid;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_data;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    issue_stage u_issue (.clk, .rst_n, .issue_valid, .issue_op, .issue_rs1, .issue_rs2,
                         .issue_rd, .issue_imm, .rf_rdata1, .rf_rdata2, .rf_raddr1,
                         .rf_raddr2, .ex_valid, .ex_op, .ex_rs1, .ex_rs2, .ex_rd,
                         .ex_opa, .ex_opb);

    reg_file u_rf (.clk, .rst_n, .rf_raddr1, .rf_raddr2, .wb_we, .wb_rd, .wb_data,
                   .rf_rdata1, .rf_rdata2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute with bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    operand_forward u_fwd (.ex_rs1, .ex_rs2, .ex_opa, .ex_opb, .mem_valid, .mem_rd,
                           .mem_data, .wb_we, .wb_rd, .wb_data, .fwd_opa, .fwd_opb);

    alu_exec u_alu (.clk, .rst_n, .ex_valid, .ex_op, .ex_rd, .fwd_opa, .fwd_opb,
                    .mem_valid, .mem_rd, .mem_data);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    writeback_stage u_wb (.clk, .rst_n, .mem_valid, .mem_rd, .mem_data, .wb_we, .wb_rd,
                          .wb_data, .result_valid, .result_rd, .result_data);

endmodule

// File: sim/exec_pipe_checker.sv
`timescale 1ns/10ps

module exec_pipe_checker
    import exec_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    input  alu_op_e               issue_op,
    input  logic [REG_ADDR_W-1:0] issue_rs1,
    input  logic [REG_ADDR_W-1:0] issue_rs2,
    input  logic [REG_ADDR_W-1:0] issue_rd,
    input  logic [IMM_W-1:0]      issue_imm,
    input  logic                  result_valid,
    input  logic [REG_ADDR_W-1:0] result_rd,
    input  logic [XLEN-1:0]       result_data,
    output int                    data_errs,
    output int                    rd_errs,
    output int                    timing_errs,
    output int                    pending
);

    localparam int LATENCY = 3;                     // Issue edge to retire edge

    logic [XLEN-1:0]       model_regs [NUM_REGS];   // Architectural state in program order
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [XLEN-1:0]       exp_data_q [$];
    int                    exp_cycle_q [$];
    int                    cycle;                   // Falling edges seen so far

    // Result of one instruction against the in-order register model
    function automatic logic [XLEN-1:0] expected_result(
        input alu_op_e               op,
        input logic [REG_ADDR_W-1:0] rs1,
        input logic [REG_ADDR_W-1:0] rs2,
        input logic [IMM_W-1:0]      imm
    );
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[5:0];
            OP_SRL:  return a >> b[5:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_ADDI: return a + {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
            default: return 'x;
        endcase
    endfunction

    initial begin
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;                     // Matches the state after reset
        end
        cycle       = 0;
        pending     = 0;
        data_errs   = 0;
        rd_errs     = 0;
        timing_errs = 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue side sampled on the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        logic [XLEN-1:0] res;
        if (rst_n && issue_valid) begin
            res = expected_result(issue_op, issue_rs1, issue_rs2, issue_imm);
            if (issue_rd != '0) begin
                model_regs[issue_rd] = res;         // x0 stays zero
            end
            exp_rd_q.push_back(issue_rd);
            exp_data_q.push_back(res);
            exp_cycle_q.push_back(cycle);
            pending = exp_rd_q.size();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Retire side sampled mid-cycle where outputs are stable
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        int                    issued;
        cycle = cycle + 1;
        if (rst_n) begin
            if (result_valid === 1'b1) begin
                if (exp_rd_q.size() == 0) begin
                    $display("At %0t: a result retired with no instruction outstanding", $time);
                    timing_errs++;
                end else begin
                    rd     = exp_rd_q.pop_front();
                    data   = exp_data_q.pop_front();
                    issued = exp_cycle_q.pop_front();
                    if (result_rd !== rd) begin
                        $display("** Error at %0t: result_rd expected %0d, got %0d",
                                 $time, rd, result_rd);
                        rd_errs++;
                    end
                    if (result_data !== data) begin
                        $display("** Error at %0t: result_data expected %h, got %h",
                                 $time, data, result_data);
                        data_errs++;
                    end
                    if (cycle - issued != LATENCY) begin
                        $display("** Error at %0t: result latency expected %0d, got %0d",
                                 $time, LATENCY, cycle - issued);
                        timing_errs++;
                    end
                end
            end else if (result_valid !== 1'b0) begin
                $display("At %0t: result_valid is unknown", $time);
                timing_errs++;
            end
            if (exp_cycle_q.size() > 0 && cycle - exp_cycle_q[0] > LATENCY) begin
                $display("At %0t: the result for rd %0d issued in cycle %0d was lost",
                         $time, exp_rd_q[0], exp_cycle_q[0]);
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cycle_q.pop_front());
                timing_errs++;
            end
            pending = exp_rd_q.size();
        end
    end

endmodule

// File: sim/tb_exec_pipe.sv
`timescale 1ns/10ps

module tb_exec_pipe
    import exec_pipe_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int N_DIRECTED    = 20;
    localparam int N_RANDOM      = 400;
    localparam int N_OPS         = N_DIRECTED + N_RANDOM;
    localparam int MARGIN_CYCLES = 20;
    localparam int WATCHDOG_NS   = N_OPS * 2 * CLK_PERIOD + MARGIN_CYCLES * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    alu_op_e               issue_op;
    logic [REG_ADDR_W-1:0] issue_rs1;
    logic [REG_ADDR_W-1:0] issue_rs2;
    logic [REG_ADDR_W-1:0] issue_rd;
    logic [IMM_W-1:0]      issue_imm;
    logic                  result_valid;
    logic [REG_ADDR_W-1:0] result_rd;
    logic [XLEN-1:0]       result_data;
    int                    data_errs;
    int                    rd_errs;
    int                    timing_errs;
    int                    pending;
    logic [31:0]           lfsr = 32'd81623;

    exec_pipe_top UUT (.clk, .rst_n, .issue_valid, .issue_op, .issue_rs1, .issue_rs2,
                       .issue_rd, .issue_imm, .result_valid, .result_rd, .result_data);

    exec_pipe_checker u_checker (.clk, .rst_n, .issue_valid, .issue_op, .issue_rs1,
                                 .issue_rs2, .issue_rd, .issue_imm, .result_valid,
                                 .result_rd, .result_data, .data_errs, .rd_errs,
                                 .timing_errs, .pending);

    // Galois form with taps x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                 // One step per bit taken
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic issue_instr(input alu_op_e op, input logic [REG_ADDR_W-1:0] rs1,
                               input logic [REG_ADDR_W-1:0] rs2,
                               input logic [REG_ADDR_W-1:0] rd, input logic [IMM_W-1:0] imm);
        @(negedge clk);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_rd    = rd;
        issue_imm   = imm;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        alu_op_e               op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [IMM_W-1:0]      imm;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rd    = '0;
        issue_imm   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) idle_cycle();                    // result_valid must stay low here

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Directed dependency distances
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd1, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd2, 16'(rand_bits(16)));
        issue_instr(OP_ADD,  5'd1, 5'd2, 5'd3, 16'd0);      // x1 from MEM/WB and x2 from EX/MEM
        issue_instr(OP_SUB,  5'd3, 5'd3, 5'd4, 16'd0);      // Both operands from EX/MEM
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd5, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd5, 16'(rand_bits(16)));
        issue_instr(OP_ADD,  5'd5, 5'd5, 5'd6, 16'd0);      // Younger x5 wins
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd7, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd7, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd8, 16'(rand_bits(16)));
        issue_instr(OP_OR,   5'd7, 5'd8, 5'd9, 16'd0);      // MEM/WB x7 over register file x7
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd10, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd11, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd12, 16'(rand_bits(16)));
        issue_instr(OP_SLL,  5'd10, 5'd11, 5'd13, 16'd0);   // x10 through write-through
        issue_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 16'(rand_bits(16)));
        issue_instr(OP_ADDI, 5'd0, 5'd0, 5'd15, 16'(rand_bits(16)));
        issue_instr(OP_ADD,  5'd0, 5'd0, 5'd14, 16'd0);     // x0 must not forward
        issue_instr(OP_SLT,  5'd4, 5'd1, 5'd16, 16'd0);
        issue_instr(OP_SRL,  5'd3, 5'd2, 5'd17, 16'd0);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Random mix over a small destination pool
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        for (int i = 0; i < N_RANDOM; i++) begin
            if (rand_bits(2) == 0) begin
                idle_cycle();                       // About one cycle in four is empty
            end
            if (i < N_RANDOM / 4 && rand_bits(1) == 1) begin
                op = OP_ADDI;                       // Fill registers early
            end else begin
                op = alu_op_e'(rand_bits(4) % 9);
            end
            rs1 = REG_ADDR_W'(rand_bits(3));
            rs2 = REG_ADDR_W'(rand_bits(3));
            rd  = REG_ADDR_W'(rand_bits(3));
            imm = IMM_W'(rand_bits(16));
            issue_instr(op, rs1, rs2, rd, imm);
        end
        idle_cycle();

        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);                  // Any extra result would show here

        $display("Errors: data %0d, rd %0d, timing %0d", data_errs, rd_errs, timing_errs);
        if (data_errs + rd_errs + timing_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: exec_pipe.f
src/exec_pipe_pkg.sv
src/reg_file.sv
src/issue_stage.sv
src/operand_forward.sv
src/alu_exec.sv
src/writeback_stage.sv
src/exec_pipe_top.sv
sim/exec_pipe_checker.sv
sim/tb_exec_pipe.sv
